// File: design/capture_pkg.sv
package capture_pkg;

    localparam int SAMPLE_W          = 12;
    localparam int WORD_W            = 64;
    localparam int SAMPLES_PER_GROUP = 16;  // 16 x 12 bits is exactly three words

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;

    typedef struct packed {
        logic [7:0]  presamples;   // samples kept from before the trigger
        logic [15:0] max_samples;  // total stored, presamples included
        logic [7:0]  downsample;   // samples skipped between stored ones
    } capture_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_e;

    typedef struct packed {
        logic cfg_error;
        logic presamp_error;
        logic clip_error;
        logic overflow;
    } capture_flags_t;

    typedef struct packed {
        logic         arm_pulse;
        logic         trig_pulse;
        sample_t      sample;  // adc data delayed to line up with trig_pulse
        capture_cfg_t cfg;
    } capture_event_t;

endpackage

// File: design/capture_trigger_decode.sv
`timescale 1ns/1ns

module capture_trigger_decode (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  capture_pkg::sample_t        adc_data_i,
    input  logic                        arm_i,
    input  logic                        trigger_i,
    input  capture_pkg::capture_cfg_t   cfg_i,
    output capture_pkg::capture_event_t event_o,
    output logic                        cfg_error_o
);

    logic                      arm_q;
    logic                      trig_q;
    logic                      arm_pulse;
    logic                      trig_pulse;
    logic                      arm_edge;
    capture_pkg::sample_t      sample_q;
    capture_pkg::capture_cfg_t cfg_q;

    assign arm_edge = arm_i && !arm_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_q       <= 1'b0;
            trig_q      <= 1'b0;
            arm_pulse   <= 1'b0;
            trig_pulse  <= 1'b0;
            cfg_q       <= '0;
            cfg_error_o <= 1'b0;
        end else begin
            arm_q      <= arm_i;
            trig_q     <= trigger_i;
            arm_pulse  <= arm_edge;
            trig_pulse <= trigger_i && !trig_q;
            if (arm_edge) begin
                cfg_q       <= cfg_i;
                cfg_error_o <= 1'b0;
                // downsampling and presamples together are not supported
                if ((cfg_i.downsample != '0) && (cfg_i.presamples != '0)) begin
                    cfg_q.presamples <= '0;
                    cfg_error_o      <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        sample_q <= adc_data_i;  // same delay as the edge detect
    end

    assign event_o = '{arm_pulse: arm_pulse, trig_pulse: trig_pulse,
                       sample: sample_q, cfg: cfg_q};

endmodule

// File: design/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic
) (
    input  logic     adc_sampleclk,
    input  logic     reset,
    input  logic     clear_i,
    input  logic     wr_i,
    input  payload_t data_i,
    input  logic     rd_i,
    output payload_t data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign full_o  = (count == (AW+1)'(DEPTH));
    assign empty_o = (count == '0);
    assign do_wr   = wr_i && !full_o;   // write when full is dropped
    assign do_rd   = rd_i && !empty_o;
    assign data_o  = mem[rd_ptr];       // head of queue shows through

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= data_i;
    end

endmodule

// File: design/capture_sequencer.sv
`timescale 1ns/1ns

module capture_sequencer #(
    parameter int SAMPLE_DEPTH = 64
) (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  capture_pkg::capture_event_t event_i,
    input  logic                        fifo_full_i,
    input  logic                        fifo_empty_i,
    input  capture_pkg::sample_t        fifo_data_i,
    input  logic                        word_space_i,
    output logic                        fifo_clear_o,
    output logic                        fifo_wr_o,
    output logic                        fifo_rd_o,
    output logic                        sample_valid_o,
    output capture_pkg::sample_t        sample_o,
    output logic                        last_o,
    output logic                        armed_o,
    output logic                        presamp_error_o,
    output logic                        clip_error_o,
    output logic                        overflow_o
);

    capture_pkg::capture_state_e state;
    capture_pkg::capture_cfg_t   cfg;
    logic [7:0]                  pre_target;
    logic [7:0]                  pre_cnt;
    logic [15:0]                 store_cnt;
    logic [7:0]                  ds_ctr;
    logic                        trig_acc;
    logic                        store;
    logic                        drain;
    logic                        fwd_rd;

    assign cfg = event_i.cfg;

    // window capped one below the fifo depth so the trigger sample still fits
    assign pre_target = (cfg.presamples >= 8'(SAMPLE_DEPTH - 1)) ?
                        8'(SAMPLE_DEPTH - 1) : cfg.presamples;

    assign trig_acc = (state == capture_pkg::PRESAMP_FULL) && event_i.trig_pulse
                      && !event_i.arm_pulse;

    always_comb begin
        case (state)
            capture_pkg::PRESAMP_FILLING: store = 1'b1;
            capture_pkg::PRESAMP_FULL:    store = trig_acc || (pre_target != '0);
            capture_pkg::TRIGGERED:       store = (ds_ctr == cfg.downsample);
            default:                      store = 1'b0;
        endcase
    end

    // drop the oldest presample while waiting, so the window stays put
    assign drain  = (state == capture_pkg::PRESAMP_FULL) && (pre_target != '0) && !trig_acc;
    assign fwd_rd = ((state == capture_pkg::TRIGGERED) || (state == capture_pkg::DONE))
                    && !fifo_empty_i && word_space_i && !event_i.arm_pulse;

    assign fifo_clear_o = event_i.arm_pulse;
    assign fifo_wr_o    = store;
    assign fifo_rd_o    = drain || fwd_rd;
    assign armed_o      = state inside {capture_pkg::PRESAMP_FILLING,
                                        capture_pkg::PRESAMP_FULL, capture_pkg::TRIGGERED};

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state           <= capture_pkg::IDLE;
            pre_cnt         <= '0;
            store_cnt       <= '0;
            ds_ctr          <= '0;
            sample_valid_o  <= 1'b0;
            last_o          <= 1'b0;
            presamp_error_o <= 1'b0;
            clip_error_o    <= 1'b0;
            overflow_o      <= 1'b0;
        end else begin
            sample_valid_o <= fwd_rd;
            last_o         <= 1'b0;
            // trigger restarts the count so the trigger sample is always kept
            ds_ctr <= (trig_acc || (ds_ctr == cfg.downsample)) ? '0 : ds_ctr + 8'd1;
            if (fifo_wr_o && fifo_full_i)
                overflow_o <= 1'b1;
            if (fwd_rd && ((fifo_data_i == '1) || (fifo_data_i == '0)))
                clip_error_o <= 1'b1;

            if (event_i.arm_pulse) begin
                state           <= (pre_target != '0) ? capture_pkg::PRESAMP_FILLING
                                                      : capture_pkg::PRESAMP_FULL;
                pre_cnt         <= '0;
                store_cnt       <= '0;
                presamp_error_o <= 1'b0;
                clip_error_o    <= 1'b0;
                overflow_o      <= 1'b0;
            end else begin
                case (state)
                    capture_pkg::PRESAMP_FILLING: begin
                        if (event_i.trig_pulse)
                            presamp_error_o <= 1'b1;  // too early, window not full
                        pre_cnt <= pre_cnt + 8'd1;
                        if (pre_cnt == pre_target - 8'd1)
                            state <= capture_pkg::PRESAMP_FULL;
                    end
                    capture_pkg::PRESAMP_FULL: begin
                        if (trig_acc) begin
                            store_cnt <= 16'(pre_target) + 16'd1;
                            state     <= (16'(pre_target) + 16'd1 >= cfg.max_samples) ?
                                         capture_pkg::DONE : capture_pkg::TRIGGERED;
                        end
                    end
                    capture_pkg::TRIGGERED: begin
                        if (store) begin
                            store_cnt <= store_cnt + 16'd1;
                            if (store_cnt + 16'd1 >= cfg.max_samples)
                                state <= capture_pkg::DONE;
                        end
                    end
                    capture_pkg::DONE: begin
                        if (fifo_empty_i) begin  // everything handed to the packer
                            last_o <= 1'b1;
                            state  <= capture_pkg::IDLE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fwd_rd)
            sample_o <= fifo_data_i;
    end

endmodule

// File: design/word_packer.sv
`timescale 1ns/1ns

module word_packer (
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  logic                 sample_valid_i,
    input  capture_pkg::sample_t sample_i,
    input  logic                 last_i,
    input  logic                 word_full_i,
    output logic                 word_wr_o,
    output capture_pkg::word_t   word_o,
    output logic                 stream_end_o
);

    localparam int ACC_W = capture_pkg::WORD_W + capture_pkg::SAMPLE_W;
    localparam int CNT_W = $clog2(ACC_W);
    localparam int GRP_W = $clog2(capture_pkg::SAMPLES_PER_GROUP);

    logic [ACC_W-1:0]     acc;  // pending bits at the bottom, oldest highest
    logic [ACC_W-1:0]     acc_next;
    logic [CNT_W-1:0]     nbits;
    logic [CNT_W-1:0]     nbits_next;
    logic [GRP_W-1:0]     grp_cnt;
    logic                 filling;
    logic                 push;
    capture_pkg::sample_t push_data;

    // filler waits while the word fifo is full
    assign push       = sample_valid_i || (filling && !word_full_i);
    assign push_data  = sample_valid_i ? sample_i : '0;
    assign acc_next   = {acc[capture_pkg::WORD_W-1:0], push_data};
    assign nbits_next = nbits + CNT_W'(capture_pkg::SAMPLE_W);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            nbits        <= '0;
            grp_cnt      <= '0;
            filling      <= 1'b0;
            word_wr_o    <= 1'b0;
            stream_end_o <= 1'b0;
        end else begin
            word_wr_o    <= 1'b0;
            stream_end_o <= 1'b0;
            if (last_i) begin
                if (grp_cnt == '0)
                    stream_end_o <= 1'b1;  // final word already went out
                else
                    filling <= 1'b1;
            end
            if (push) begin
                grp_cnt <= grp_cnt + 1'b1;
                if (nbits_next >= CNT_W'(capture_pkg::WORD_W)) begin
                    nbits     <= nbits_next - CNT_W'(capture_pkg::WORD_W);
                    word_wr_o <= 1'b1;
                end else begin
                    nbits <= nbits_next;
                end
                // group boundary means no bits left over
                if (filling && (grp_cnt == GRP_W'(capture_pkg::SAMPLES_PER_GROUP - 1))) begin
                    filling      <= 1'b0;
                    stream_end_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (push) begin
            acc <= acc_next;
            if (nbits_next >= CNT_W'(capture_pkg::WORD_W))
                word_o <= capture_pkg::word_t'(acc_next >> (nbits_next - 
                          CNT_W'(capture_pkg::WORD_W)));
        end
    end

endmodule

// File: design/word_output.sv
`timescale 1ns/1ns

module word_output (
    input  logic               adc_sampleclk,
    input  logic               reset,
    input  logic               arm_pulse_i,
    input  logic               empty_i,
    input  capture_pkg::word_t data_i,
    input  logic               stream_end_i,
    output logic               rd_o,
    output logic               word_req_o,
    output capture_pkg::word_t word_o,
    input  logic               word_ack_i,
    output logic               capture_done_o
);

    typedef enum logic [1:0] {
        HS_IDLE,     // holding register free
        HS_REQ,      // req high, waiting for ack
        HS_RELEASE   // req dropped, waiting for ack low
    } hs_state_e;

    hs_state_e hs;
    logic      ended;
    logic      hs_free;

    assign rd_o    = (hs == HS_IDLE) && !empty_i && !arm_pulse_i;
    assign hs_free = (hs == HS_IDLE) || ((hs == HS_RELEASE) && !word_ack_i);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            hs             <= HS_IDLE;
            word_req_o     <= 1'b0;
            ended          <= 1'b0;
            capture_done_o <= 1'b0;
        end else begin
            case (hs)
                HS_IDLE: if (rd_o) begin
                    word_req_o <= 1'b1;
                    hs         <= HS_REQ;
                end
                HS_REQ: if (word_ack_i) begin
                    word_req_o <= 1'b0;
                    hs         <= HS_RELEASE;
                end
                default: if (!word_ack_i) hs <= HS_IDLE;
            endcase
            if (stream_end_i)
                ended <= 1'b1;  // no more words after this point
            if (ended && empty_i && hs_free)
                capture_done_o <= 1'b1;
            if (arm_pulse_i) begin
                ended          <= 1'b0;
                capture_done_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (rd_o)
            word_o <= data_i;  // held until the handshake is over
    end

endmodule

// File: design/capture_top.sv
`timescale 1ns/1ns

module capture_top #(
    parameter int SAMPLE_DEPTH = 64,
    parameter int WORD_DEPTH   = 8
) (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  capture_pkg::sample_t        adc_data_i,
    input  logic                        arm_i,
    input  logic                        trigger_i,
    input  capture_pkg::capture_cfg_t   cfg_i,
    input  logic                        word_ack_i,
    output logic                        word_req_o,
    output capture_pkg::word_t          word_o,
    output logic                        armed_o,
    output logic                        capture_done_o,
    output capture_pkg::capture_flags_t flags_o
);

    capture_pkg::capture_event_t evt;
    capture_pkg::sample_t        s_dout;
    capture_pkg::sample_t        pk_sample;
    capture_pkg::word_t          w_din;
    capture_pkg::word_t          w_dout;
    logic cfg_error, presamp_error, clip_error, overflow;
    logic fifo_clear, s_wr, s_rd, s_full, s_empty;
    logic pk_valid, pk_last, stream_end;
    logic w_wr, w_rd, w_full, w_empty;

    capture_trigger_decode u_decode (
        .adc_sampleclk, .reset, .adc_data_i, .arm_i, .trigger_i, .cfg_i,
        .event_o     (evt),
        .cfg_error_o (cfg_error)
    );

    capture_sequencer #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_execute (
        .adc_sampleclk, .reset,
        .event_i         (evt),
        .fifo_full_i     (s_full),
        .fifo_empty_i    (s_empty),
        .fifo_data_i     (s_dout),
        .word_space_i    (!w_full),  // packer needs 5+ samples per word, so no spill
        .fifo_clear_o    (fifo_clear),
        .fifo_wr_o       (s_wr),
        .fifo_rd_o       (s_rd),
        .sample_valid_o  (pk_valid),
        .sample_o        (pk_sample),
        .last_o          (pk_last),
        .armed_o,
        .presamp_error_o (presamp_error),
        .clip_error_o    (clip_error),
        .overflow_o      (overflow)
    );

    sample_fifo #(.DEPTH(SAMPLE_DEPTH), .payload_t(capture_pkg::sample_t)) u_sample_fifo (
        .adc_sampleclk, .reset,
        .clear_i (fifo_clear),
        .wr_i    (s_wr),
        .data_i  (evt.sample),
        .rd_i    (s_rd),
        .data_o  (s_dout),
        .full_o  (s_full),
        .empty_o (s_empty)
    );

    word_packer u_packer (
        .adc_sampleclk, .reset,
        .sample_valid_i (pk_valid),
        .sample_i       (pk_sample),
        .last_i         (pk_last),
        .word_full_i    (w_full),
        .word_wr_o      (w_wr),
        .word_o         (w_din),
        .stream_end_o   (stream_end)
    );

    sample_fifo #(.DEPTH(WORD_DEPTH), .payload_t(capture_pkg::word_t)) u_word_fifo (
        .adc_sampleclk, .reset,
        .clear_i (fifo_clear),
        .wr_i    (w_wr),
        .data_i  (w_din),
        .rd_i    (w_rd),
        .data_o  (w_dout),
        .full_o  (w_full),
        .empty_o (w_empty)
    );

    word_output u_output (
        .adc_sampleclk, .reset,
        .arm_pulse_i  (evt.arm_pulse),
        .empty_i      (w_empty),
        .data_i       (w_dout),
        .stream_end_i (stream_end),
        .rd_o         (w_rd),
        .word_req_o, .word_o, .word_ack_i, .capture_done_o
    );

    assign flags_o = '{cfg_error: cfg_error, presamp_error: presamp_error,
                       clip_error: clip_error, overflow: overflow};

endmodule

// File: verification/capture_tb.sv
`timescale 1ns/1ns

module capture_tb;

    localparam int          NROWS       = 9;
    localparam int unsigned SEED        = 32'h8ea1;
    localparam int          CLEAN_WORDS = 12;  // 64 samples, one full sample fifo

    typedef struct packed {
        logic [7:0]                  pre;
        logic [15:0]                 maxs;
        logic [7:0]                  ds;
        logic [7:0]                  tdel;      // arm to trigger, in cycles
        logic [7:0]                  early;     // early trigger cycle, 0 for none
        logic [7:0]                  ack_max;
        logic                        clip_on;
        logic signed [15:0]          clip_off;  // forced sample, relative to trigger
        capture_pkg::sample_t        clip_val;
        capture_pkg::capture_flags_t flags;     // cfg, presamp, clip, overflow
    } row_t;

    localparam row_t ROWS [NROWS] = '{
        '{8'd0,  16'd40,  8'd0, 8'd3,  8'd0, 8'd3,  1'b0, 16'sd0,  12'h000, 4'b0000},
        '{8'd0,  16'd48,  8'd0, 8'd5,  8'd0, 8'd0,  1'b0, 16'sd0,  12'h000, 4'b0000},
        '{8'd10, 16'd50,  8'd0, 8'd20, 8'd0, 8'd4,  1'b0, 16'sd0,  12'h000, 4'b0000},
        '{8'd0,  16'd30,  8'd3, 8'd4,  8'd0, 8'd2,  1'b0, 16'sd0,  12'h000, 4'b0000},
        '{8'd8,  16'd20,  8'd2, 8'd12, 8'd0, 8'd2,  1'b0, 16'sd0,  12'h000, 4'b1000},
        '{8'd20, 16'd40,  8'd0, 8'd40, 8'd6, 8'd3,  1'b0, 16'sd0,  12'h000, 4'b0100},
        '{8'd0,  16'd33,  8'd0, 8'd2,  8'd0, 8'd1,  1'b1, 16'sd7,  12'hfff, 4'b0010},
        '{8'd4,  16'd25,  8'd0, 8'd10, 8'd0, 8'd2,  1'b1, -16'sd2, 12'h000, 4'b0010},
        '{8'd0,  16'd600, 8'd0, 8'd3,  8'd0, 8'd20, 1'b0, 16'sd0,  12'h000, 4'b0001}
    };

    logic                        adc_sampleclk;
    logic                        reset;
    capture_pkg::sample_t        adc_data_i;
    logic                        arm_i;
    logic                        trigger_i;
    capture_pkg::capture_cfg_t   cfg_i;
    logic                        word_ack_i;
    logic                        word_req_o;
    capture_pkg::word_t          word_o;
    logic                        armed_o;
    logic                        capture_done_o;
    capture_pkg::capture_flags_t flags_o;

    capture_pkg::sample_t applied [$];  // every sample driven, one per cycle
    capture_pkg::word_t   got_words [$];
    capture_pkg::word_t   exp_words [$];
    capture_pkg::sample_t force_val;
    int                   force_idx   = -1;
    int                   ack_max_cur = 0;
    int                   cycles      = 0;
    int                   limit       = 0;

    capture_top DUT (.*);

    initial begin
        adc_sampleclk = 1'b0;
        forever #4 adc_sampleclk = ~adc_sampleclk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // never 0 and never all ones, so only forced samples can clip
    function automatic capture_pkg::sample_t adc_pattern(input int n);
        return capture_pkg::sample_t'((n * 1237 + 291) % 4093 + 1);
    endfunction

    task automatic tick();
        @(posedge adc_sampleclk);
        #1;
    endtask

    task automatic step();
        capture_pkg::sample_t v;
        tick();
        v = adc_pattern(applied.size());
        if (applied.size() == force_idx)
            v = force_val;
        adc_data_i = v;
        applied.push_back(v);
    endtask

    // stored samples per the capture rules, packed msb first with zero filler
    task automatic build_expected(input row_t row, input int trig_idx);
        int         pre_eff;
        int         total;
        int         n;
        int         idx;
        logic [191:0] grp;
        capture_pkg::sample_t s;
        exp_words.delete();
        pre_eff = (row.ds != '0) ? 0 : int'(row.pre);  // cfg error drops presamples
        total   = (int'(row.maxs) > pre_eff) ? int'(row.maxs) : pre_eff + 1;
        n       = ((total + 15) / 16) * 16;
        grp     = '0;
        for (int i = 0; i < n; i++) begin
            s = '0;
            if (i < total) begin
                if (i < pre_eff)
                    idx = trig_idx - pre_eff + i;
                else
                    idx = trig_idx + (i - pre_eff) * (int'(row.ds) + 1);
                s = applied[idx];
            end
            grp = {grp[179:0], s};
            if (i % 16 == 15) begin  // 16 samples make three words
                exp_words.push_back(grp[191:128]);
                exp_words.push_back(grp[127:64]);
                exp_words.push_back(grp[63:0]);
            end
        end
    endtask

    always @(posedge adc_sampleclk) begin
        cycles = cycles + 1;
        if ((limit > 0) && (cycles > limit))
            report_error($sformatf("timeout: capture not done after %0d cycles", cycles));
    end

    // consumer side of the req/ack handshake, random ack delay
    initial begin : ack_responder
        int dly;
        void'($urandom(SEED));
        forever begin
            tick();
            if (word_req_o) begin
                dly = int'($urandom % 32'(ack_max_cur + 1));
                repeat (dly) tick();
                assert (!capture_done_o)
                    else report_error($sformatf("[FAIL] %0t: done high with a word pending",
                                                $time));
                got_words.push_back(word_o);
                word_ack_i = 1'b1;
                do begin
                    tick();
                end while (word_req_o);
                word_ack_i = 1'b0;
            end
        end
    end

    initial begin
        row_t row;
        int   arm_idx;
        int   trig_idx;
        int   k;
        logic finished;
        reset      = 1'b1;
        adc_data_i = '0;
        arm_i      = 1'b0;
        trigger_i  = 1'b0;
        cfg_i      = '0;
        word_ack_i = 1'b0;
        for (int r = 0; r < NROWS; r++)
            limit = limit + 40 * int'(ROWS[r].maxs) + 200;
        repeat (8) @(posedge adc_sampleclk);
        #1 reset = 1'b0;

        for (int r = 0; r < NROWS; r++) begin
            row         = ROWS[r];
            got_words.delete();
            ack_max_cur = int'(row.ack_max);
            cfg_i       = '{presamples: row.pre, max_samples: row.maxs, downsample: row.ds};
            arm_idx     = applied.size();
            force_idx   = row.clip_on ? arm_idx + int'(row.tdel) + int'(row.clip_off) : -1;
            force_val   = row.clip_val;
            trig_idx    = 0;
            k           = 0;
            finished    = 1'b0;
            while (!finished) begin
                step();
                if (k == 0)
                    arm_i = 1'b1;
                if (k == 3)
                    arm_i = 1'b0;
                if (k == 1)
                    assert (!armed_o)
                        else report_error($sformatf("[FAIL] %0t: row %0d armed too early",
                                                    $time, r));
                if (k == 2)
                    assert (armed_o && !capture_done_o)
                        else report_error($sformatf("[FAIL] %0t: row %0d arm not applied",
                                                    $time, r));
                if ((row.early != '0) && (k == int'(row.early)))
                    trigger_i = 1'b1;  // lands inside the presample fill
                if ((row.early != '0) && (k == int'(row.early) + 2))
                    trigger_i = 1'b0;
                if (k == int'(row.tdel)) begin
                    trigger_i = 1'b1;
                    trig_idx  = applied.size() - 1;
                end
                if (k == int'(row.tdel) + 3)
                    trigger_i = 1'b0;
                if ((k > int'(row.tdel) + 3) && capture_done_o)
                    finished = 1'b1;
                k++;
            end

            build_expected(row, trig_idx);
            assert (flags_o === row.flags)
                else report_error($sformatf("[FAIL] %0t: row %0d flags %b expected %b",
                                            $time, r, flags_o, row.flags));
            assert (!word_req_o)
                else report_error($sformatf("[FAIL] %0t: row %0d req high after done",
                                            $time, r));
            if (row.flags.overflow) begin
                // drops start only once the sample fifo is full
                // so the words from its first fill stay exact
                assert ((got_words.size() >= CLEAN_WORDS) && (got_words.size() % 3 == 0))
                    else report_error($sformatf("[FAIL] %0t: row %0d got %0d words",
                                                $time, r, got_words.size()));
                for (int i = 0; i < CLEAN_WORDS; i++)
                    assert (got_words[i] === exp_words[i])
                        else report_error($sformatf("[FAIL] %0t: row %0d word %0d %h expected %h",
                                                    $time, r, i, got_words[i], exp_words[i]));
            end else begin
                assert (got_words.size() == exp_words.size())
                    else report_error($sformatf("[FAIL] %0t: row %0d got %0d words, expected %0d",
                                                $time, r, got_words.size(), exp_words.size()));
                foreach (got_words[i])
                    assert (got_words[i] === exp_words[i])
                        else report_error($sformatf("[FAIL] %0t: row %0d word %0d %h expected %h",
                                                    $time, r, i, got_words[i], exp_words[i]));
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: compile.f
design/capture_pkg.sv
design/capture_trigger_decode.sv
design/sample_fifo.sv
design/capture_sequencer.sv
design/word_packer.sv
design/word_output.sv
design/capture_top.sv
verification/capture_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module capture_tb -f compile.f -o capture_sim \
    && ./obj_dir/capture_sim \
    || exit 1
